// ==== source/pipe5_config.svh ====
`ifndef PIPE5_CONFIG_SVH
`define PIPE5_CONFIG_SVH

// Data and address width
`define XLEN 32

// Register file index width
`define REG_W 5

// Trap vector after reset, direct mode
`define MTVEC_RESET 32'h0000_0100

// Machine timer width
`define MTIME_W 32

`endif

// ==== source/pipe5_hazard_pkg.sv ====
`default_nettype none

`include "pipe5_config.svh"

package pipe5_hazard_pkg;

  typedef logic [`XLEN-1:0]    word_t;
  typedef logic [`REG_W-1:0]   reg_idx_t;
  typedef logic [3:0]          cause_t;
  typedef logic [11:0]         csr_addr_t;
  typedef logic [`MTIME_W-1:0] mtime_t;

  // Status reported by the pipeline
  typedef struct packed {
    logic     iren;
    logic     i_mem_busy;
    logic     dren;
    logic     dwen;
    logic     d_mem_busy;
    logic     jump;
    logic     branch;
    logic     mispredict;
    logic     load;
    reg_idx_t reg_rd;
    reg_idx_t reg_rs1;
    reg_idx_t reg_rs2;
    logic     csr;
    logic     ifence;
    logic     dflushed;
    logic     iflushed;
    logic     f_stall;
    word_t    epc;
    word_t    badaddr_i;
    word_t    badaddr_d;
  } pipe_status_t;

  typedef struct packed {
    logic fault_insn;
    logic mal_insn;
    logic illegal_insn;
    logic fault_l;
    logic mal_l;
    logic fault_s;
    logic mal_s;
    logic breakpoint;
    logic env_m;
    logic ret;
  } exc_flags_t;

  // Controls back to the pipeline
  typedef struct packed {
    logic  pc_en;
    logic  stall;
    logic  npc_sel;
    logic  if_id_flush;
    logic  id_ex_flush;
    logic  ex_mem_flush;
    logic  ifence_flush;
    logic  csr_flush;
    logic  insert_priv_pc;
    word_t priv_pc;
  } hazard_ctrl_t;

  typedef struct packed {
    logic       exception;  // Any exception group
    logic       ret;
    logic       intr_take;  // Interrupt already gated by exceptions
    exc_flags_t flags;
    word_t      epc;
    word_t      badaddr;
  } trap_req_t;

  typedef enum logic [1:0] {
    T_RUN,
    T_ENTER,
    T_RETURN
  } trap_state_t;

  // Machine cause numbers
  localparam cause_t CAUSE_MAL_INSN     = 4'd0;
  localparam cause_t CAUSE_FAULT_INSN   = 4'd1;
  localparam cause_t CAUSE_ILLEGAL_INSN = 4'd2;
  localparam cause_t CAUSE_BREAKPOINT   = 4'd3;
  localparam cause_t CAUSE_MAL_L        = 4'd4;
  localparam cause_t CAUSE_FAULT_L      = 4'd5;
  localparam cause_t CAUSE_MAL_S        = 4'd6;
  localparam cause_t CAUSE_FAULT_S      = 4'd7;
  localparam cause_t CAUSE_ENV_M        = 4'd11;
  localparam cause_t CAUSE_TIMER_INTR   = 4'd7;  // Machine timer interrupt

  // CSR addresses, mtimecmp sits in the custom machine range
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MTIMECMP = 12'h7c0;

  localparam int MSTATUS_MIE_BIT = 3;

endpackage

`default_nettype wire

// ==== source/pipe5_hazard_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe5_hazard_top
  import pipe5_hazard_pkg::*;
(
  input  logic         CLK,
  input  logic         rst_n,
  input  pipe_status_t status,
  input  exc_flags_t   exc,
  input  logic         csr_wen,
  input  csr_addr_t    csr_addr,
  input  word_t        csr_wdata,
  output hazard_ctrl_t ctrl,
  output word_t        mepc,
  output cause_t       mcause,
  output word_t        mtval,
  output logic         timer_pending
);

  hazard_ctrl_t hazard;
  trap_req_t    trap_req;
  logic         intr_pending, intr_taken, pipe_clear;
  logic         insert_pc, priv_pc_sel;
  logic         capture_trap, capture_ret;
  word_t        mtvec;
  mtime_t       mtimecmp;
  mtime_t       mtime;

  pipe5_hazard_unit i_pipe5_hazard_unit (
    .status       (status),
    .exc          (exc),
    .intr_pending (intr_pending),
    .intr_taken   (intr_taken),
    .pipe_clear   (pipe_clear),
    .hazard       (hazard),
    .trap_req     (trap_req)
  );

  prv_trap_fsm i_prv_trap_fsm (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .trap_req     (trap_req),
    .insert_pc    (insert_pc),
    .priv_pc_sel  (priv_pc_sel),
    .intr_taken   (intr_taken),
    .pipe_clear   (pipe_clear),
    .capture_trap (capture_trap),
    .capture_ret  (capture_ret)
  );

  prv_timer i_prv_timer (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .mtimecmp      (mtimecmp),
    .mtime         (mtime),
    .timer_pending (timer_pending)
  );

  prv_csr_regs i_prv_csr_regs (
    .CLK (CLK), .rst_n (rst_n),
    .csr_wen (csr_wen), .csr_addr (csr_addr), .csr_wdata (csr_wdata),
    .trap_req (trap_req), .capture_trap (capture_trap), .capture_ret (capture_ret),
    .timer_pending (timer_pending),
    .mtvec (mtvec), .mepc (mepc), .mtval (mtval), .mcause (mcause),
    .mtimecmp (mtimecmp), .intr_pending (intr_pending)
  );

  // Hazard controls plus the inserted trap or return PC
  always_comb begin
    ctrl                = hazard;
    ctrl.insert_priv_pc = insert_pc;
    ctrl.priv_pc        = priv_pc_sel ? mepc : mtvec;
  end

endmodule

`default_nettype wire

// ==== source/pipe5_hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe5_hazard_unit
  import pipe5_hazard_pkg::*;
(
  input  pipe_status_t status,
  input  exc_flags_t   exc,
  input  logic         intr_pending,
  input  logic         intr_taken,
  input  logic         pipe_clear,
  output hazard_ctrl_t hazard,
  output trap_req_t    trap_req
);

  logic wait_for_imem;
  logic wait_for_dmem;
  logic redirect;
  logic ifence_flush;
  logic load_use;
  logic e_fetch_stage;
  logic e_decode_stage;
  logic e_execute_stage;
  logic any_exception;
  logic trap_event;
  logic pipe_flush;

  // Hold the PC while either memory is still busy
  assign wait_for_imem = status.iren & status.i_mem_busy;
  assign wait_for_dmem = (status.dren | status.dwen) & status.d_mem_busy;

  assign redirect = status.jump | (status.branch & status.mispredict);

  // ifence has to wait for both caches
  assign ifence_flush = status.ifence & (~status.dflushed | ~status.iflushed);

  assign e_fetch_stage   = exc.fault_insn | exc.mal_insn;
  assign e_decode_stage  = exc.illegal_insn | exc.breakpoint | exc.env_m;
  assign e_execute_stage = exc.fault_l | exc.mal_l | exc.fault_s | exc.mal_s;

  assign any_exception = e_fetch_stage | e_decode_stage | e_execute_stage;
  assign trap_event    = any_exception | intr_taken | exc.ret;

  assign pipe_flush = redirect | ifence_flush | status.csr | trap_event;

  // RAW on a load result
  assign load_use = status.load &
                    ((status.reg_rd == status.reg_rs1) | (status.reg_rd == status.reg_rs2));

  always_comb begin
    hazard.pc_en        = ~wait_for_imem & ~wait_for_dmem;
    hazard.stall        = status.f_stall |
                          (load_use & ~status.csr & ~ifence_flush & ~trap_event);
    hazard.npc_sel      = redirect & ~trap_event;  // Trap vector wins over branch target
    hazard.if_id_flush  = pipe_flush;
    hazard.id_ex_flush  = pipe_flush;
    hazard.ex_mem_flush = pipe_flush;
    hazard.ifence_flush = ifence_flush;
    hazard.csr_flush    = status.csr;
    // Filled in by the trap sequencer at the top level
    hazard.insert_priv_pc = 1'b0;
    hazard.priv_pc        = '0;
  end

  always_comb begin
    trap_req.exception = any_exception;
    trap_req.ret       = exc.ret;
    // No interrupt while an exception is pending or a trap is in flight
    trap_req.intr_take = intr_pending & ~any_exception & ~pipe_clear;
    trap_req.flags     = exc;
    trap_req.epc       = status.epc;
    if (exc.mal_insn | exc.fault_insn) begin
      trap_req.badaddr = status.badaddr_i;  // Fetch side address
    end else begin
      trap_req.badaddr = status.badaddr_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/prv_csr_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipe5_config.svh"

module prv_csr_regs
  import pipe5_hazard_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      csr_wen,
  input  csr_addr_t csr_addr,
  input  word_t     csr_wdata,
  input  trap_req_t trap_req,
  input  logic      capture_trap,
  input  logic      capture_ret,
  input  logic      timer_pending,
  output word_t     mtvec,
  output word_t     mepc,
  output word_t     mtval,
  output cause_t    mcause,
  output mtime_t    mtimecmp,
  output logic      intr_pending
);

  word_t  mtvec_q, mepc_q, mtval_q;
  cause_t mcause_q;
  mtime_t mtimecmp_q;
  logic   mie_q;
  cause_t cause_d;
  logic   tval_zero;  // No faulting address for this cause

  // Highest priority source first
  always_comb begin
    tval_zero = 1'b0;
    if (trap_req.flags.fault_insn) cause_d = CAUSE_FAULT_INSN;
    else if (trap_req.flags.mal_insn) cause_d = CAUSE_MAL_INSN;
    else if (trap_req.flags.illegal_insn) cause_d = CAUSE_ILLEGAL_INSN;
    else if (trap_req.flags.breakpoint) begin
      cause_d   = CAUSE_BREAKPOINT;
      tval_zero = 1'b1;
    end else if (trap_req.flags.env_m) begin
      cause_d   = CAUSE_ENV_M;
      tval_zero = 1'b1;
    end
    else if (trap_req.flags.mal_l) cause_d = CAUSE_MAL_L;
    else if (trap_req.flags.fault_l) cause_d = CAUSE_FAULT_L;
    else if (trap_req.flags.mal_s) cause_d = CAUSE_MAL_S;
    else if (trap_req.flags.fault_s) cause_d = CAUSE_FAULT_S;
    else begin
      cause_d   = CAUSE_TIMER_INTR;
      tval_zero = 1'b1;  // Interrupts carry no address
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_q    <= `MTVEC_RESET;
      mepc_q     <= '0;
      mtval_q    <= '0;
      mcause_q   <= '0;
      mtimecmp_q <= '1;  // Timer quiet until programmed
      mie_q      <= 1'b0;
    end else if (capture_trap) begin
      mepc_q   <= trap_req.epc;
      mtval_q  <= tval_zero ? '0 : trap_req.badaddr;
      mcause_q <= cause_d;
      mie_q    <= 1'b0;
    end else if (capture_ret) begin
      mie_q <= 1'b1;
    end else if (csr_wen) begin
      case (csr_addr)
        CSR_MTVEC:    mtvec_q <= {csr_wdata[$bits(word_t)-1:2], 2'b00};  // Direct mode only
        CSR_MEPC:     mepc_q <= csr_wdata;
        CSR_MSTATUS:  mie_q <= csr_wdata[MSTATUS_MIE_BIT];
        CSR_MTIMECMP: mtimecmp_q <= mtime_t'(csr_wdata);
        default: ;
      endcase
    end
  end

  assign mtvec        = mtvec_q;
  assign mepc         = mepc_q;
  assign mtval        = mtval_q;
  assign mcause       = mcause_q;
  assign mtimecmp     = mtimecmp_q;
  assign intr_pending = timer_pending & mie_q;

endmodule

`default_nettype wire

// ==== source/prv_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module prv_timer
  import pipe5_hazard_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  mtime_t mtimecmp,
  output mtime_t mtime,
  output logic   timer_pending
);

  mtime_t mtime_q;
  logic   pending_q;

  // Free running, wraps at the top
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Registered compare, follows mtimecmp rewrites as a level
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= (mtime_q >= mtimecmp);
    end
  end

  assign mtime         = mtime_q;
  assign timer_pending = pending_q;

endmodule

`default_nettype wire

// ==== source/prv_trap_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module prv_trap_fsm
  import pipe5_hazard_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  trap_req_t trap_req,
  output logic      insert_pc,
  output logic      priv_pc_sel,  // 0 selects mtvec, 1 selects mepc
  output logic      intr_taken,
  output logic      pipe_clear,
  output logic      capture_trap,
  output logic      capture_ret
);

  trap_state_t state_q;
  trap_state_t state_d;
  logic        intr_q;  // Current entry came from the interrupt
  logic        take_trap;
  logic        take_ret;

  // Only accept new events from T_RUN
  assign take_trap = (state_q == T_RUN) & (trap_req.exception | trap_req.intr_take);
  assign take_ret  = (state_q == T_RUN) & trap_req.ret & ~take_trap;

  always_comb begin
    state_d = state_q;
    case (state_q)
      T_RUN: begin
        if (take_trap) begin
          state_d = T_ENTER;
        end else if (take_ret) begin
          state_d = T_RETURN;
        end
      end
      T_ENTER:  state_d = T_RUN;
      T_RETURN: state_d = T_RUN;
      default:  state_d = T_RUN;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= T_RUN;
      intr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take_trap) begin
        intr_q <= trap_req.intr_take & ~trap_req.exception;
      end
    end
  end

  // CSR capture on the accepting edge
  assign capture_trap = take_trap;
  assign capture_ret  = take_ret;

  // One insertion cycle per accepted event
  assign insert_pc   = (state_q == T_ENTER) | (state_q == T_RETURN);
  assign priv_pc_sel = (state_q == T_RETURN);
  assign intr_taken  = (state_q == T_ENTER) & intr_q;
  assign pipe_clear  = (state_q != T_RUN);

endmodule

`default_nettype wire

// ==== tb/pipe5_hazard_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe5_hazard_checker
  import pipe5_hazard_pkg::*;
(
  input logic         CLK,
  input logic         rst_n,
  input hazard_ctrl_t ctrl,
  input exc_flags_t   exc,
  input logic         intr_taken,
  input mtime_t       mtime,
  input mtime_t       mtimecmp,
  input logic         timer_pending
);

  // PC insertion is a single cycle pulse
  insert_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    ctrl.insert_priv_pc |=> !ctrl.insert_priv_pc)
    else $error("insert_priv_pc held for two cycles");

  // Trap vector wins over a redirect, raw flags straight from the pipeline
  npc_vs_trap: assert property (@(posedge CLK) disable iff (!rst_n)
    ctrl.npc_sel |-> !(|exc) && !intr_taken)
    else $error("npc_sel high during a trap event");

  ctrl_known: assert property (@(posedge CLK) disable iff (!rst_n)
    !$isunknown(ctrl))
    else $error("control output unknown");

  // Count is already past the compare value when pending rises
  pending_after_compare: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(timer_pending) |-> mtime > mtimecmp)
    else $error("timer_pending set before mtime reached mtimecmp");

endmodule

bind pipe5_hazard_top pipe5_hazard_checker i_pipe5_hazard_checker (.*);

`default_nettype wire

// ==== tb/tb_pipe5_hazard_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipe5_config.svh"

module tb_pipe5_hazard_top
  import pipe5_hazard_pkg::*;
;

  typedef struct {
    pipe_status_t status;
    exc_flags_t   exc;
    logic         wen;
    csr_addr_t    addr;
    word_t        wdata;
    logic         wait_pend;  // Repeat until the timer fires
  } row_t;

  logic CLK, rst_n, csr_wen, timer_pending;
  pipe_status_t status;
  exc_flags_t exc;
  csr_addr_t csr_addr;
  word_t csr_wdata, mepc, mtval;
  cause_t mcause;
  hazard_ctrl_t ctrl;

  row_t rows[$];
  logic [31:0] lfsr = 32'hdea1_2a6e;
  int cycles = 0;
  int limit = 100000;

  // Reference model state
  logic [1:0] m_state;  // 0 run, 1 enter, 2 return
  logic m_intr, m_mie, m_pend;
  word_t m_mtvec, m_mepc, m_mtval;
  cause_t m_mcause;
  mtime_t m_cmp, m_time;
  hazard_ctrl_t e_ctrl;
  logic take_trap, take_ret, itake, exc_any;

  pipe5_hazard_top i_pipe5_hazard_top (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run took more cycles than allowed");
      $display("Something failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic pipe_status_t base_status();
    pipe_status_t s;
    s = '0;
    s.iren = 1'b1;
    s.dflushed = 1'b1;
    s.iflushed = 1'b1;
    s.reg_rd = reg_idx_t'(take_bits(5));
    s.reg_rs1 = s.reg_rd ^ 5'd1;  // No match unless a row sets one
    s.reg_rs2 = s.reg_rd ^ 5'd2;
    s.epc = take_bits(32);
    s.badaddr_i = take_bits(32);
    s.badaddr_d = take_bits(32);
    return s;
  endfunction

  task automatic push(input pipe_status_t s, input exc_flags_t x, input logic w,
                      input csr_addr_t a, input word_t d, input logic wp);
    row_t r;
    r.status = s;
    r.exc = x;
    r.wen = w;
    r.addr = a;
    r.wdata = d;
    r.wait_pend = wp;
    rows.push_back(r);
  endtask

  task automatic idle(input int n);
    repeat (n) push(base_status(), '0, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic model_comb(input row_t r);
    logic redirect, ifl, ld_use, tevent;
    redirect = r.status.jump | (r.status.branch & r.status.mispredict);
    ifl = r.status.ifence & ~(r.status.dflushed & r.status.iflushed);
    ld_use = r.status.load & ((r.status.reg_rd == r.status.reg_rs1) |
                              (r.status.reg_rd == r.status.reg_rs2));
    exc_any = r.exc.fault_insn | r.exc.mal_insn | r.exc.illegal_insn | r.exc.fault_l |
              r.exc.mal_l | r.exc.fault_s | r.exc.mal_s | r.exc.breakpoint | r.exc.env_m;
    tevent = exc_any | r.exc.ret | (m_state == 2'd1 && m_intr);
    itake = m_pend & m_mie & ~exc_any & (m_state == 2'd0);
    take_trap = (m_state == 2'd0) & (exc_any | itake);
    take_ret = (m_state == 2'd0) & r.exc.ret & ~take_trap;
    e_ctrl.pc_en = ~(r.status.iren & r.status.i_mem_busy) &
                   ~((r.status.dren | r.status.dwen) & r.status.d_mem_busy);
    e_ctrl.stall = r.status.f_stall | (ld_use & ~r.status.csr & ~ifl & ~tevent);
    e_ctrl.npc_sel = redirect & ~tevent;
    e_ctrl.if_id_flush = redirect | ifl | r.status.csr | tevent;
    e_ctrl.id_ex_flush = e_ctrl.if_id_flush;
    e_ctrl.ex_mem_flush = e_ctrl.if_id_flush;
    e_ctrl.ifence_flush = ifl;
    e_ctrl.csr_flush = r.status.csr;
    e_ctrl.insert_priv_pc = (m_state != 2'd0);
    e_ctrl.priv_pc = (m_state == 2'd2) ? m_mepc : m_mtvec;
  endtask

  task automatic model_step(input row_t r);
    cause_t c;
    logic no_addr;
    no_addr = 1'b0;
    if (r.exc.fault_insn) c = CAUSE_FAULT_INSN;
    else if (r.exc.mal_insn) c = CAUSE_MAL_INSN;
    else if (r.exc.illegal_insn) c = CAUSE_ILLEGAL_INSN;
    else if (r.exc.breakpoint) {c, no_addr} = {CAUSE_BREAKPOINT, 1'b1};
    else if (r.exc.env_m) {c, no_addr} = {CAUSE_ENV_M, 1'b1};
    else if (r.exc.mal_l) c = CAUSE_MAL_L;
    else if (r.exc.fault_l) c = CAUSE_FAULT_L;
    else if (r.exc.mal_s) c = CAUSE_MAL_S;
    else if (r.exc.fault_s) c = CAUSE_FAULT_S;
    else {c, no_addr} = {CAUSE_TIMER_INTR, 1'b1};
    m_pend = (m_time >= m_cmp);
    m_time = m_time + 1'b1;
    if (take_trap) begin
      m_mepc = r.status.epc;
      if (no_addr) m_mtval = '0;
      else if (r.exc.fault_insn | r.exc.mal_insn) m_mtval = r.status.badaddr_i;
      else m_mtval = r.status.badaddr_d;
      m_mcause = c;
      m_mie = 1'b0;
      m_intr = itake;
      m_state = 2'd1;
    end else if (take_ret) begin
      m_mie = 1'b1;
      m_state = 2'd2;
    end else begin
      m_state = 2'd0;
      if (r.wen) begin
        case (r.addr)
          CSR_MTVEC: m_mtvec = {r.wdata[31:2], 2'b00};
          CSR_MEPC: m_mepc = r.wdata;
          CSR_MSTATUS: m_mie = r.wdata[MSTATUS_MIE_BIT];
          CSR_MTIMECMP: m_cmp = r.wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic fail_now();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_ctrl(input hazard_ctrl_t got, input hazard_ctrl_t exp);
    if (got !== exp) begin
      $display("error: ctrl got %h expected %h", got, exp);
      fail_now();
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_cause(input cause_t got, input cause_t exp);
    if (got !== exp) begin
      $display("error: mcause got %h expected %h", got, exp);
      fail_now();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic apply_row(input row_t r);
    status = r.status;
    exc = r.exc;
    csr_wen = r.wen;
    csr_addr = r.addr;
    csr_wdata = r.wdata;
    #5;
    model_comb(r);
    check_ctrl(ctrl, e_ctrl);
    check_word("mepc", mepc, m_mepc);
    check_word("mtval", mtval, m_mtval);
    check_cause(mcause, m_mcause);
    check_bit("timer_pending", timer_pending, m_pend);
    model_step(r);
    @(posedge CLK);
    #1;
  endtask

  initial begin
    pipe_status_t s;
    exc_flags_t x;
    status = '0;
    exc = '0;
    csr_wen = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    rst_n = 1'b0;
    {m_state, m_intr, m_mie, m_pend, m_mepc, m_mtval, m_mcause, m_time} = '0;
    m_mtvec = `MTVEC_RESET;
    m_cmp = '1;

    push(base_status(), '0, 1'b1, CSR_MTVEC, 32'h0000_0843, 1'b0);
    // Load-use cases
    s = base_status();
    s.load = 1'b1;
    s.reg_rs1 = s.reg_rd;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.load = 1'b1;
    s.reg_rs2 = s.reg_rd;
    push(s, '0, 0, '0, '0, 0);
    s.csr = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s.csr = 1'b0;
    s.ifence = 1'b1;
    s.iflushed = 1'b0;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.load = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s.reg_rs1 = s.reg_rd;
    x = '0;
    x.mal_l = 1'b1;
    push(s, x, 0, '0, '0, 0);
    idle(2);
    // Redirects
    s = base_status();
    s.jump = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.branch = 1'b1;
    s.mispredict = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s.mispredict = 1'b0;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.jump = 1'b1;
    x = '0;
    x.illegal_insn = 1'b1;
    push(s, x, 0, '0, '0, 0);
    idle(2);
    s = base_status();
    s.ifence = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s.dflushed = 1'b0;
    push(s, '0, 0, '0, '0, 0);
    // Memory wait
    s = base_status();
    s.i_mem_busy = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.dren = 1'b1;
    s.d_mem_busy = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.dwen = 1'b1;
    s.d_mem_busy = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    s = base_status();
    s.d_mem_busy = 1'b1;
    push(s, '0, 0, '0, '0, 0);
    // Exception priority, then an event during T_ENTER
    x = '0;
    x.fault_l = 1'b1;
    x.mal_l = 1'b1;
    x.env_m = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    idle(2);
    x = '0;
    x.breakpoint = 1'b1;
    x.mal_s = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    push(base_status(), x, 0, '0, '0, 0);
    idle(1);
    x = '0;
    x.fault_s = 1'b1;
    x.mal_insn = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    idle(2);
    // Timer interrupt, return, and an exception that holds the interrupt off
    push(base_status(), '0, 1'b1, CSR_MTIMECMP, 32'd300, 1'b0);
    push(base_status(), '0, 1'b1, CSR_MSTATUS, 32'h8, 1'b0);
    push(base_status(), '0, 0, '0, '0, 1'b1);
    idle(3);
    x = '0;
    x.ret = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    idle(3);
    push(base_status(), '0, 1'b1, CSR_MSTATUS, 32'h8, 1'b0);
    x = '0;
    x.illegal_insn = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    idle(3);
    x = '0;
    x.ret = 1'b1;
    push(base_status(), x, 0, '0, '0, 0);
    idle(4);
    limit = 20 * rows.size() + 512;

    repeat (3) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].wait_pend) begin
        while (!m_pend) apply_row(rows[i]);
      end else begin
        apply_row(rows[i]);
      end
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/pipe5_hazard_pkg.sv
source/pipe5_hazard_unit.sv
source/prv_trap_fsm.sv
source/prv_timer.sv
source/prv_csr_regs.sv
source/pipe5_hazard_top.sv
tb/pipe5_hazard_checker.sv
tb/tb_pipe5_hazard_top.sv
